//--- files.f
+incdir+src
src/st_bus_pkg.sv
src/st_rtc_pkg.sv
src/cpu_bus_if.sv
src/st_bus_decode.sv
src/rtc_rp5c15.sv
src/mste_ctrl_regs.sv
src/bus_speed_ctrl.sv
src/audio_mix.sv
src/st_io_top.sv
dv/st_io_asserts.sv
dv/st_io_checker.sv
dv/st_io_tb.sv

//--- dv/st_io_tb.sv
`timescale 1ns/100ps

module st_io_tb;

	localparam logic [2:0] OP_INIT = 3'd0;
	localparam logic [2:0] OP_RD   = 3'd1;
	localparam logic [2:0] OP_WR   = 3'd2;
	localparam logic [2:0] OP_NODT = 3'd3;
	localparam logic [2:0] OP_IDLE = 3'd4;
	localparam logic [2:0] OP_AUD  = 3'd5;

	// time 23:59:48 on 25.12.24 with day of week 3
	localparam logic [63:0] RTC_WORD = 64'h0003_2412_2523_5948;

	// mode column is {steroids, mste}
	typedef struct packed {
		logic [2:0]  op;
		logic [23:0] addr;
		logic [15:0] data;
		logic [1:0]  mode;
		logic [63:0] rtc;
		logic [31:0] exp;
	} row_t;

	row_t rows[$];

	logic        clk_32 = 1'b0;
	logic        xsint;
	logic        as_n_i, rw_i, uds_n_i, lds_n_i;
	logic [22:0] addr_i;
	logic [15:0] data_i, data_o;
	logic        dtack_n_o;
	logic        mste_mode_i, steroids_i;
	logic [63:0] rtc_i;
	logic        use_16mhz_o, turbo_o;
	logic [9:0]  ym_l_i, ym_r_i;
	logic [7:0]  dma_l_i, dma_r_i;
	logic [14:0] audio_l_o, audio_r_o;

	logic        chk_stb;
	int          chk_row;
	logic [2:0]  chk_op;
	logic [31:0] chk_exp;
	int          chk_err, chk_rows;
	int          asrt_fails;
	int          row_idx;
	int          cyc_cnt = 0;
	int          cyc_limit;
	integer      seed = 32'hd8e8_d05d;

	st_io_top i_dut (.*);

	st_io_checker i_chk (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.as_n_i      (as_n_i),
		.dtack_n_i   (dtack_n_o),
		.data_i      (data_o),
		.use_16mhz_i (use_16mhz_o),
		.turbo_i     (turbo_o),
		.audio_l_i   (audio_l_o),
		.audio_r_i   (audio_r_o),
		.chk_stb_i   (chk_stb),
		.row_i       (chk_row),
		.op_i        (chk_op),
		.exp_i       (chk_exp),
		.err_cnt_o   (chk_err),
		.row_cnt_o   (chk_rows)
	);

	always #50 clk_32 = ~clk_32;

	always @(posedge clk_32) begin
		cyc_cnt++;
		if (cyc_cnt > cyc_limit) begin
			$display("timeout: the run did not complete within %0d cycles", cyc_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// offset removal, widening and 15-bit wraparound in integer form
	function automatic logic [14:0] expected_mix(input logic [9:0] ym, input logic [7:0] dma);
		integer ys;
		integer ds;
		integer sum;
		ys  = ym;
		ys  = ys - 512;
		ds  = dma;
		ds  = ds - 128;
		sum = ys * 16 + (((ys + 1024) % 1024) >> 6) + ds * 64 + (((ds + 256) % 256) >> 2);
		return sum[14:0];
	endfunction

	task automatic add_row(input logic [2:0] op, input logic [23:0] addr, input logic [15:0] data,
		input logic [1:0] mode, input logic [63:0] rtc, input logic [31:0] exp);
		rows.push_back({op, addr, data, mode, rtc, exp});
	endtask

	task automatic build_table();
		add_row(OP_INIT, 24'h000000, 16'h0000, 2'b00, RTC_WORD, 32'h0);
		// bank 0 time registers
		add_row(OP_RD,   24'hfffc21, 16'h0000, 2'b00, RTC_WORD, 32'hfff8);
		add_row(OP_RD,   24'hfffc2d, 16'h0000, 2'b00, RTC_WORD, 32'hfff3);
		add_row(OP_RD,   24'hfffc33, 16'h0000, 2'b00, RTC_WORD, 32'hfff2);
		add_row(OP_RD,   24'hfffc39, 16'h0000, 2'b00, RTC_WORD, 32'hfff4);
		add_row(OP_RD,   24'hfffc3b, 16'h0000, 2'b00, RTC_WORD, 32'hfff8);
		add_row(OP_RD,   24'hfffc3d, 16'h0000, 2'b00, RTC_WORD, 32'hfff0);
		add_row(OP_RD,   24'hfffc3f, 16'h0000, 2'b00, RTC_WORD, 32'hfffc);
		// no time from the controller
		add_row(OP_RD,   24'hfffc21, 16'h0000, 2'b00, 64'h0,    32'hffff);
		add_row(OP_RD,   24'hfffc3b, 16'h0000, 2'b00, 64'h0,    32'hffff);
		// bank 1 scratch
		add_row(OP_WR,   24'hfffc3b, 16'h0001, 2'b00, RTC_WORD, 32'h0);
		add_row(OP_WR,   24'hfffc27, 16'h000a, 2'b00, RTC_WORD, 32'h0);
		add_row(OP_WR,   24'hfffc2f, 16'h0005, 2'b00, RTC_WORD, 32'h0);
		add_row(OP_RD,   24'hfffc27, 16'h0000, 2'b00, RTC_WORD, 32'hfffa);
		add_row(OP_RD,   24'hfffc2f, 16'h0000, 2'b00, RTC_WORD, 32'hfff5);
		add_row(OP_RD,   24'hfffc3b, 16'h0000, 2'b00, RTC_WORD, 32'hfff9);
		add_row(OP_WR,   24'hfffc3b, 16'h0000, 2'b00, RTC_WORD, 32'h0);
		add_row(OP_RD,   24'hfffc21, 16'h0000, 2'b00, RTC_WORD, 32'hfff8);
		add_row(OP_NODT, 24'hff8801, 16'h0000, 2'b00, RTC_WORD, 32'h0);
		// Mega STe control register and speed
		add_row(OP_IDLE, 24'h000000, 16'h0000, 2'b01, RTC_WORD, 32'h0);
		add_row(OP_WR,   24'hff8e21, 16'h0001, 2'b01, RTC_WORD, 32'h0);
		add_row(OP_RD,   24'hff8e21, 16'h0000, 2'b01, RTC_WORD, 32'hfffd);
		add_row(OP_IDLE, 24'h000000, 16'h0000, 2'b01, RTC_WORD, 32'h2);
		add_row(OP_WR,   24'hff8e21, 16'h0002, 2'b01, RTC_WORD, 32'h0);
		add_row(OP_RD,   24'hff8e21, 16'h0000, 2'b01, RTC_WORD, 32'hfffe);
		add_row(OP_IDLE, 24'h000000, 16'h0000, 2'b01, RTC_WORD, 32'h1);
		add_row(OP_NODT, 24'hff8e21, 16'h0000, 2'b00, RTC_WORD, 32'h0);
		add_row(OP_IDLE, 24'h000000, 16'h0000, 2'b11, RTC_WORD, 32'h3);
		add_row(OP_RD,   24'hff8e00, 16'h0000, 2'b01, RTC_WORD, 32'hffff);
		add_row(OP_IDLE, 24'h000000, 16'h0000, 2'b00, RTC_WORD, 32'h1);
		// samples drawn while the rows run
		repeat (6)
			add_row(OP_AUD, 24'h000000, 16'h0000, 2'b00, RTC_WORD, 32'h0);
	endtask

	// one 68000 cycle that waits up to 8 cycles for DTACK
	task automatic bus_cycle(input logic [23:0] byte_addr, input logic wr, input logic [15:0] wdata);
		int n;
		addr_i  = byte_addr[23:1];
		data_i  = wdata;
		rw_i    = ~wr;
		// odd byte on the low lane and even address as a word
		uds_n_i = byte_addr[0];
		lds_n_i = 1'b0;
		as_n_i  = 1'b0;
		n = 0;
		while (dtack_n_o && n < 8) begin
			@(negedge clk_32);
			n++;
		end
		if (!dtack_n_o)
			@(negedge clk_32);
		as_n_i  = 1'b1;
		rw_i    = 1'b1;
		uds_n_i = 1'b1;
		lds_n_i = 1'b1;
		repeat (2) @(negedge clk_32);
	endtask

	task automatic apply_row(input int idx);
		row_t        r;
		logic [31:0] exp;
		r           = rows[idx];
		exp         = r.exp;
		mste_mode_i = r.mode[0];
		steroids_i  = r.mode[1];
		rtc_i       = r.rtc;
		case (r.op)
			OP_RD, OP_NODT: bus_cycle(r.addr, 1'b0, r.data);
			OP_WR:          bus_cycle(r.addr, 1'b1, r.data);
			OP_IDLE:        repeat (4) @(negedge clk_32);
			OP_AUD: begin
				ym_l_i  = $random(seed);
				ym_r_i  = $random(seed);
				dma_l_i = $random(seed);
				dma_r_i = $random(seed);
				exp = {2'b00, expected_mix(ym_l_i, dma_l_i), expected_mix(ym_r_i, dma_r_i)};
				@(negedge clk_32);
				// inputs move on so only a one-cycle register still shows the sum
				ym_l_i  = 10'h200;
				ym_r_i  = 10'h200;
				dma_l_i = 8'h80;
				dma_r_i = 8'h80;
			end
			default: ;
		endcase
		chk_row = idx;
		chk_op  = r.op;
		chk_exp = exp;
		chk_stb = 1'b1;
		@(negedge clk_32);
		chk_stb = 1'b0;
	endtask

	initial begin
		xsint       = 1'b0;
		as_n_i      = 1'b1;
		rw_i        = 1'b1;
		uds_n_i     = 1'b1;
		lds_n_i     = 1'b1;
		addr_i      = '0;
		data_i      = '0;
		mste_mode_i = 1'b0;
		steroids_i  = 1'b0;
		rtc_i       = '0;
		// mid-scale inputs mix to zero
		ym_l_i      = 10'h200;
		ym_r_i      = 10'h200;
		dma_l_i     = 8'h80;
		dma_r_i     = 8'h80;
		chk_stb     = 1'b0;
		chk_row     = 0;
		chk_op      = OP_INIT;
		chk_exp     = '0;
		build_table();
		cyc_limit = rows.size() * 12 + 5;
		repeat (5) @(negedge clk_32);
		xsint = 1'b1;
		for (row_idx = 0; row_idx < rows.size(); row_idx++)
			apply_row(row_idx);
		repeat (2) @(negedge clk_32);
		asrt_fails = i_dut.i_decode.i_hs_asserts.fail_cnt + i_dut.i_speed.i_speed_asserts.fail_cnt;
		$display("rows checked %0d of %0d, rows failed %0d, assertion failures %0d",
			chk_rows, rows.size(), chk_err, asrt_fails);
		if (chk_err == 0 && asrt_fails == 0 && chk_rows == rows.size())
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- dv/st_io_checker.sv
`timescale 1ns/100ps
`include "st_io_cfg.svh"

module st_io_checker (
	input  logic        clk_32,
	input  logic        xsint,
	input  logic        as_n_i,
	input  logic        dtack_n_i,
	input  logic [15:0] data_i,
	input  logic        use_16mhz_i,
	input  logic        turbo_i,
	input  logic [14:0] audio_l_i,
	input  logic [14:0] audio_r_i,
	input  logic        chk_stb_i,
	input  int          row_i,
	input  logic [2:0]  op_i,
	input  logic [31:0] exp_i,
	output int          err_cnt_o,
	output int          row_cnt_o
);

	localparam logic [2:0] OP_INIT = 3'd0;
	localparam logic [2:0] OP_RD   = 3'd1;
	localparam logic [2:0] OP_WR   = 3'd2;
	localparam logic [2:0] OP_NODT = 3'd3;
	localparam logic [2:0] OP_IDLE = 3'd4;
	localparam logic [2:0] OP_AUD  = 3'd5;

	int          as_cnt;
	int          dt_delay;
	logic        dt_seen;
	logic        rel_bad;
	logic        prev_as_hi;
	logic [15:0] rd_word;

	task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAIL row %0d: %s got 0x%h expected 0x%h", row_i, name, got, exp);
		err_cnt_o++;
	endtask

	task automatic plain_fail(input string msg);
		$display("row %0d went wrong: %s", row_i, msg);
		err_cnt_o++;
	endtask

	task automatic judge_row();
		row_cnt_o++;
		case (op_i)
			OP_INIT:
				if (dtack_n_i !== 1'b1)
					value_fail("dtack_n_o", dtack_n_i, 1);
				else if ({use_16mhz_i, turbo_i} !== 2'b00)
					value_fail("{use_16mhz_o,turbo_o}", {use_16mhz_i, turbo_i}, 0);
				else if (audio_l_i !== '0 || audio_r_i !== '0)
					value_fail("{audio_l_o,audio_r_o}", {audio_l_i, audio_r_i}, 0);
				else
					$display("row %0d ok", row_i);
			OP_RD, OP_WR:
				if (!dt_seen)
					plain_fail("the bus cycle got no DTACK");
				else if (dt_delay != `ST_DTACK_DELAY)
					value_fail("dtack_n_o delay", dt_delay, `ST_DTACK_DELAY);
				else if (rel_bad)
					plain_fail("DTACK stayed low after AS_N rose");
				else if (op_i == OP_RD && rd_word !== exp_i[15:0])
					value_fail("data_o", rd_word, exp_i[15:0]);
				else
					$display("row %0d ok", row_i);
			OP_NODT:
				if (dt_seen)
					plain_fail("an unmapped cycle was answered with DTACK");
				else
					$display("row %0d ok", row_i);
			OP_IDLE:
				if ({use_16mhz_i, turbo_i} !== exp_i[1:0])
					value_fail("{use_16mhz_o,turbo_o}", {use_16mhz_i, turbo_i}, exp_i[1:0]);
				else
					$display("row %0d ok", row_i);
			OP_AUD:
				if (audio_l_i !== exp_i[29:15])
					value_fail("audio_l_o", audio_l_i, exp_i[29:15]);
				else if (audio_r_i !== exp_i[14:0])
					value_fail("audio_r_o", audio_r_i, exp_i[14:0]);
				else
					$display("row %0d ok", row_i);
			default:
				plain_fail("the row has an unknown operation");
		endcase
	endtask

	always @(posedge clk_32) begin
		if (!xsint) begin
			as_cnt     = 0;
			dt_seen    = 1'b0;
			rel_bad    = 1'b0;
			prev_as_hi = 1'b1;
			err_cnt_o  = 0;
			row_cnt_o  = 0;
		end else begin
			// DTACK must be gone one edge after AS_N is seen high
			if (prev_as_hi && !dtack_n_i)
				rel_bad = 1'b1;
			if (!as_n_i) begin
				if (!dtack_n_i && !dt_seen) begin
					dt_seen  = 1'b1;
					dt_delay = as_cnt - 1;
					rd_word  = data_i;
				end
				as_cnt = as_cnt + 1;
			end else
				as_cnt = 0;
			prev_as_hi = as_n_i;
			if (chk_stb_i) begin
				judge_row();
				dt_seen = 1'b0;
				rel_bad = 1'b0;
			end
		end
	end

endmodule

//--- dv/st_io_asserts.sv
`timescale 1ns/100ps

module st_io_asserts (
	input logic       clk_32,
	input logic       xsint,
	input logic       as_n_i,
	input logic       dtack_n_i,
	input logic       decoded_i,
	input logic [1:0] speed_i
);

	int fail_cnt = 0;

	// DTACK is low on the third edge that samples AS_N low
	dtack_delay: assert property (@(posedge clk_32) disable iff (!xsint)
		$fell(as_n_i) && decoded_i |-> dtack_n_i [*3] ##1 !dtack_n_i)
		else begin
			$error("DTACK did not fall two cycles after AS_N");
			fail_cnt++;
		end

	dtack_release: assert property (@(posedge clk_32) disable iff (!xsint)
		$rose(as_n_i) |=> dtack_n_i)
		else begin
			$error("DTACK still low one cycle after AS_N rose");
			fail_cnt++;
		end

	// no speed switch inside a bus cycle
	speed_hold: assert property (@(posedge clk_32) disable iff (!xsint)
		!as_n_i |=> $stable(speed_i))
		else begin
			$error("speed outputs changed during a bus cycle");
			fail_cnt++;
		end

endmodule

bind st_bus_decode st_io_asserts i_hs_asserts (
	.clk_32    (clk_32),
	.xsint     (xsint),
	.as_n_i    (as_n_i),
	.dtack_n_i (dtack_n_o),
	.decoded_i (tgt_d != TGT_NONE),
	.speed_i   (2'b00)
);

bind bus_speed_ctrl st_io_asserts i_speed_asserts (
	.clk_32    (clk_32),
	.xsint     (xsint),
	.as_n_i    (as_n_i),
	.dtack_n_i (1'b1),
	.decoded_i (1'b0),
	.speed_i   ({use_16mhz_o, turbo_o})
);

//--- src/st_io_top.sv
`timescale 1ns/100ps

module st_io_top import st_bus_pkg::*; (
	input  logic        clk_32,
	input  logic        xsint,

	// 68000 bus
	input  logic        as_n_i,
	input  logic        rw_i,
	input  logic        uds_n_i,
	input  logic        lds_n_i,
	input  bus_addr_t   addr_i,
	input  bus_data_t   data_i,
	output bus_data_t   data_o,
	output logic        dtack_n_o,

	// machine mode
	input  logic        mste_mode_i,
	input  logic        steroids_i,

	// time from the I/O controller
	input  logic [63:0] rtc_i,

	// cpu clocking
	output logic        use_16mhz_o,
	output logic        turbo_o,

	// audio
	input  logic [9:0]  ym_l_i,
	input  logic [9:0]  ym_r_i,
	input  logic [7:0]  dma_l_i,
	input  logic [7:0]  dma_r_i,
	output logic [14:0] audio_l_o,
	output logic [14:0] audio_r_o
);

	logic enable_16mhz;
	logic enable_cache;

	cpu_bus_if bus ();

	st_bus_decode i_decode (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.as_n_i      (as_n_i),
		.rw_i        (rw_i),
		.uds_n_i     (uds_n_i),
		.lds_n_i     (lds_n_i),
		.addr_i      (addr_i),
		.data_i      (data_i),
		.mste_mode_i (mste_mode_i),
		.steroids_i  (steroids_i),
		.bus         (bus.decoder),
		.data_o      (data_o),
		.dtack_n_o   (dtack_n_o)
	);

	rtc_rp5c15 i_rtc (
		.clk_32 (clk_32),
		.xsint  (xsint),
		.bus    (bus.rtc),
		.rtc_i  (rtc_i)
	);

	mste_ctrl_regs i_mste_ctrl (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.bus            (bus.ctrl),
		.enable_16mhz_o (enable_16mhz),
		.enable_cache_o (enable_cache)
	);

	bus_speed_ctrl i_speed (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.as_n_i         (as_n_i),
		.enable_16mhz_i (enable_16mhz),
		.enable_cache_i (enable_cache),
		.steroids_i     (steroids_i),
		.use_16mhz_o    (use_16mhz_o),
		.turbo_o        (turbo_o)
	);

	audio_mix i_audio (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.ym_l_i    (ym_l_i),
		.ym_r_i    (ym_r_i),
		.dma_l_i   (dma_l_i),
		.dma_r_i   (dma_r_i),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

endmodule

//--- src/audio_mix.sv
`timescale 1ns/100ps
`include "st_io_cfg.svh"

module audio_mix (
	input  logic        clk_32,
	input  logic        xsint,
	input  logic [9:0]  ym_l_i,
	input  logic [9:0]  ym_r_i,
	input  logic [7:0]  dma_l_i,
	input  logic [7:0]  dma_r_i,
	output logic [14:0] audio_l_o,
	output logic [14:0] audio_r_o
);

	// both samples scaled to 15 bits, then summed with wraparound
	function automatic logic [14:0] mix(input logic [9:0] ym, input logic [7:0] dma);
		logic [9:0] ym_s;
		logic [7:0] dma_s;
		ym_s  = ym - `ST_YM_OFFSET;
		dma_s = dma - `ST_DMA_OFFSET;
		return {ym_s[9], ym_s, ym_s[9:6]} + {dma_s[7], dma_s, dma_s[7:2]};
	endfunction

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			audio_l_o <= mix(ym_l_i, dma_l_i);
			audio_r_o <= mix(ym_r_i, dma_r_i);
		end
	end

endmodule

//--- src/bus_speed_ctrl.sv
`timescale 1ns/100ps
`include "st_io_cfg.svh"

module bus_speed_ctrl (
	input  logic clk_32,
	input  logic xsint,
	input  logic as_n_i,
	input  logic enable_16mhz_i,
	input  logic enable_cache_i,
	input  logic steroids_i,
	output logic use_16mhz_o,
	output logic turbo_o
);

	localparam int DIV_W = $clog2(`ST_CLK8_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`ST_CLK8_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             clk8_en;

	// free-running 8 MHz enable
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			div_cnt <= '0;
		else if (div_cnt == DIV_LAST)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign clk8_en = (div_cnt == DIV_LAST);

	// only switch speed between bus cycles
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			use_16mhz_o <= 1'b0;
			turbo_o     <= 1'b0;
		end else if (clk8_en && as_n_i) begin
			use_16mhz_o <= enable_16mhz_i | steroids_i;
			turbo_o     <= enable_cache_i | steroids_i;
		end
	end

endmodule

//--- src/mste_ctrl_regs.sv
`timescale 1ns/100ps

module mste_ctrl_regs import st_bus_pkg::*; (
	input  logic    clk_32,
	input  logic    xsint,
	cpu_bus_if.ctrl bus,
	output logic    enable_16mhz_o,
	output logic    enable_cache_o
);

	// bit 0 16 MHz, bit 1 cache
	logic [1:0] ctrl_q;
	bus_data_t  rd_word;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ctrl_q <= 2'b00;
		else if (bus.wr_stb && bus.mste_sel)
			ctrl_q <= bus.wdata[1:0];
	end

	// byte sits on the low lane, unused bits read high
	always_comb begin
		rd_word = '1;
		if (bus.mste_sel && bus.rw)
			rd_word = {8'hff, 6'h3f, ctrl_q};
		bus.mste_rdata = rd_word;
	end

	assign enable_16mhz_o = ctrl_q[0];
	assign enable_cache_o = ctrl_q[1];

endmodule

//--- src/rtc_rp5c15.sv
`timescale 1ns/100ps

module rtc_rp5c15 import st_bus_pkg::*, st_rtc_pkg::*; (
	input  logic      clk_32,
	input  logic      xsint,
	cpu_bus_if.rtc    bus,
	input  rtc_time_u rtc_i
);

	logic       bank;
	logic [3:0] scratch [16];
	logic [3:0] idx;
	logic [3:0] nib;
	logic       wr;
	bus_data_t  rd_word;

	// A4..A1 pick the register
	assign idx = bus.addr[3:0];
	assign wr  = bus.wr_stb & bus.rtc_sel;

	always_comb begin
		nib = 4'hf;
		if (idx == 4'hd)
			nib = {1'b1, 2'b00, bank};
		else if (idx == 4'he)
			nib = 4'h0;
		else if (idx == 4'hf)
			nib = 4'hc;
		else if (bank)
			nib = scratch[idx];
		else begin
			case (idx)
				4'h0: nib = rtc_i.nib[0];
				4'h1: nib = rtc_i.nib[1];
				4'h2: nib = rtc_i.nib[2];
				4'h3: nib = rtc_i.nib[3];
				4'h4: nib = rtc_i.nib[4];
				4'h5: nib = rtc_i.nib[5];
				4'h6: nib = rtc_i.f.dow[3:0];
				4'h7: nib = rtc_i.nib[6];
				4'h8: nib = rtc_i.nib[7];
				4'h9: nib = rtc_i.nib[8];
				4'ha: nib = rtc_i.nib[9];
				4'hb: nib = rtc_i.f.year[3:0];
				// TOS counts from 1980, the controller from 2000
				4'hc: nib = rtc_i.f.year[7:4] + 4'd2;
				default: nib = 4'hf;
			endcase
		end
		// no time from the controller, chip looks absent
		if (rtc_i.nib == '0)
			nib = 4'hf;
	end

	always_comb begin
		rd_word = '1;
		if (bus.rtc_sel && bus.rw)
			rd_word = {12'hfff, nib};
		bus.rtc_rdata = rd_word;
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			bank <= 1'b0;
		else if (wr && idx == 4'hd)
			bank <= bus.wdata[0];
	end

	// bank 1 scratch ram
	always_ff @(posedge clk_32) begin
		if (wr && idx != 4'hd)
			scratch[idx] <= bus.wdata[3:0];
	end

endmodule

//--- src/st_bus_decode.sv
`timescale 1ns/100ps
`include "st_io_cfg.svh"

module st_bus_decode import st_bus_pkg::*; (
	input  logic       clk_32,
	input  logic       xsint,
	input  logic       as_n_i,
	input  logic       rw_i,
	input  logic       uds_n_i,
	input  logic       lds_n_i,
	input  bus_addr_t  addr_i,
	input  bus_data_t  data_i,
	input  logic       mste_mode_i,
	input  logic       steroids_i,
	cpu_bus_if.decoder bus,
	output bus_data_t  data_o,
	output logic       dtack_n_o
);

	localparam logic [23:0] RTC_BASE  = `ST_RTC_BASE;
	localparam logic [23:0] CTRL_ADDR = `ST_MSTE_CTRL_ADDR;
	localparam logic [23:0] VME_BASE  = `ST_VME_BASE;
	localparam int CNT_W = $clog2(`ST_DTACK_DELAY + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`ST_DTACK_DELAY - 1);

	io_target_e       tgt_d;
	io_target_e       tgt_q;
	logic             active;
	logic [CNT_W-1:0] cnt;
	logic             io_page;
	logic             mste_ok;
	logic             dtack_go;
	bus_data_t        rd_word;

	// no function codes here, just the $FF page
	assign io_page = (addr_i[22:15] == 8'hff);
	// STEroids has no VME or cache register
	assign mste_ok = mste_mode_i & ~steroids_i;

	always_comb begin
		tgt_d = TGT_NONE;
		if (io_page && addr_i[14:4] == RTC_BASE[15:5])
			tgt_d = TGT_RTC;
		else if (io_page && mste_ok && !lds_n_i && addr_i[14:0] == CTRL_ADDR[15:1])
			tgt_d = TGT_MSTE_CTRL;
		else if (io_page && mste_ok && addr_i[14:3] == VME_BASE[15:4])
			tgt_d = TGT_VME;
	end

	// last delay cycle of a decoded cycle
	assign dtack_go = active & ~as_n_i & dtack_n_o & (cnt == CNT_LAST) & (tgt_q != TGT_NONE);
	assign bus.wr_stb = dtack_go & ~bus.rw;

	assign bus.rtc_sel  = (tgt_q == TGT_RTC);
	assign bus.mste_sel = (tgt_q == TGT_MSTE_CTRL);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			active    <= 1'b0;
			cnt       <= '0;
			tgt_q     <= TGT_NONE;
			dtack_n_o <= 1'b1;
			bus.rw    <= 1'b1;
			bus.uds_n <= 1'b1;
			bus.lds_n <= 1'b1;
		end else if (as_n_i) begin
			// release on the first edge with AS_N high
			active    <= 1'b0;
			tgt_q     <= TGT_NONE;
			dtack_n_o <= 1'b1;
		end else if (!active) begin
			active    <= 1'b1;
			cnt       <= '0;
			tgt_q     <= tgt_d;
			bus.rw    <= rw_i;
			bus.uds_n <= uds_n_i;
			bus.lds_n <= lds_n_i;
		end else begin
			if (cnt != CNT_LAST)
				cnt <= cnt + 1'b1;
			if (dtack_go)
				dtack_n_o <= 1'b0;
		end
	end

	// address and write data of the cycle
	always_ff @(posedge clk_32) begin
		if (!as_n_i && !active) begin
			bus.addr  <= addr_i;
			bus.wdata <= data_i;
		end
	end

	always_comb begin
		case (tgt_q)
			TGT_RTC:       rd_word = bus.rtc_rdata;
			TGT_MSTE_CTRL: rd_word = bus.mste_rdata;
			// VME and unmapped float high
			default:       rd_word = '1;
		endcase
		data_o = {bus.uds_n ? 8'hff : rd_word[15:8], bus.lds_n ? 8'hff : rd_word[7:0]};
	end

endmodule

//--- src/cpu_bus_if.sv
`timescale 1ns/100ps

interface cpu_bus_if import st_bus_pkg::*; ();

	// cycle as latched by the decoder at AS_N fall
	bus_addr_t addr;
	bus_data_t wdata;
	logic      rw;
	logic      uds_n;
	logic      lds_n;

	// one clock wide, ends on the DTACK edge
	logic      wr_stb;

	// target selects and their read words
	logic      rtc_sel;
	logic      mste_sel;
	bus_data_t rtc_rdata;
	bus_data_t mste_rdata;

	modport decoder (
		output addr, wdata, rw, uds_n, lds_n, wr_stb, rtc_sel, mste_sel,
		input  rtc_rdata, mste_rdata
	);

	modport rtc (
		input  addr, wdata, rw, wr_stb, rtc_sel,
		output rtc_rdata
	);

	modport ctrl (
		input  wdata, rw, wr_stb, mste_sel,
		output mste_rdata
	);

endinterface

//--- src/st_rtc_pkg.sv
package st_rtc_pkg;

	// time word from the I/O controller, two BCD digits per field
	typedef struct packed {
		logic [7:0] spare;
		logic [7:0] dow;
		logic [7:0] year;
		logic [7:0] month;
		logic [7:0] day;
		logic [7:0] hours;
		logic [7:0] minutes;
		logic [7:0] seconds;
	} rtc_fields_t;

	// same 64 bits, seen as sixteen nibbles or as named fields
	// nibble 0 is the seconds units digit
	typedef union packed {
		logic [15:0][3:0] nib;
		rtc_fields_t      f;
	} rtc_time_u;

endpackage

//--- src/st_bus_pkg.sv
`include "st_io_cfg.svh"

package st_bus_pkg;

	// word address, bit 0 is A1
	typedef logic [`ST_ADDR_W-1:0] bus_addr_t;

	// one bus word, D15..D0
	typedef logic [`ST_DATA_W-1:0] bus_data_t;

	// which register target a decoded cycle goes to
	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_RTC,
		TGT_MSTE_CTRL,
		TGT_VME
	} io_target_e;

endpackage

//--- src/st_io_cfg.svh
`ifndef ST_IO_CFG_SVH
`define ST_IO_CFG_SVH

// 68000 bus widths
// word address carries A23..A1
`define ST_ADDR_W 23
`define ST_DATA_W 16

// I/O map, byte addresses
// RP5C15 window, sixteen word registers
`define ST_RTC_BASE 24'hFFFC20
// word that holds the $FF8E21 cache/speed byte
`define ST_MSTE_CTRL_ADDR 24'hFF8E20
// sixteen-byte VME window
`define ST_VME_BASE 24'hFF8E00

// bus timing in clk_32 cycles
`define ST_CLK8_DIV 4
`define ST_DTACK_DELAY 2

// mid-scale of the offset-binary audio samples
`define ST_YM_OFFSET 10'h200
`define ST_DMA_OFFSET 8'h80

`endif
